// File: build.f
+incdir+.
cmp_pkg.sv
cmp_dispatch_if.sv
cmp_rs.sv
cmp_eval.sv
br_target.sv
br_resolve.sv
cmp_unit_top.sv
tb_cmp_unit.sv

// File: cmp_tb_tasks.svh
`ifndef CMP_TB_TASKS_SVH
`define CMP_TB_TASKS_SVH

// advance n edges, inputs change 0.5 ns after the edge
task automatic step(input int n);
    for (int i = 0; i < n; i++) begin
        @(posedge clk);
        #0.5;
    end
endtask

// raise the wishbone write strobe with one issue payload
task automatic put_issue(input cmp_op_t op, input word_t vj, input rob_tag_t qj,
                         input word_t vk, input word_t pc, input word_t imm,
                         input rob_tag_t tag);
    iss_op_i    = op;
    iss_is_br_i = (op != F3_SLT) && (op != F3_SLTU);
    iss_vj_i    = vj;
    iss_qj_i    = qj;
    iss_vk_i    = vk;
    iss_qk_i    = '0;
    iss_pc_i    = pc;
    iss_imm_i   = imm;
    iss_tag_i   = tag;
    wb_cyc_i    = 1'b1;
    wb_stb_i    = 1'b1;
    wb_we_i     = 1'b1;
endtask

// strobe stays up until ack or timeout
task automatic wait_ack(input int max_cyc, output logic acked);
    int n;
    acked = 1'b0;
    n     = 0;
    while (!acked && n < max_cyc) begin
        step(1);
        n++;
        if (wb_ack_o) begin
            acked              = 1'b1;
            ack_cyc[iss_tag_i] = cyc_cnt;
            wb_cyc_i           = 1'b0;
            wb_stb_i           = 1'b0;
            wb_we_i            = 1'b0;
        end
    end
endtask

// scoreboard entry from the final operand values
task automatic expect_result(input rob_tag_t tag, input cmp_op_t op, input word_t a,
                             input word_t b, input word_t pc, input word_t imm,
                             input logic chk_lat);
    logic br;
    logic bit_v;
    br            = (op != F3_SLT) && (op != F3_SLTU);
    bit_v         = rule_bit(op, a, b);
    exp_br[tag]   = br;
    exp_tk[tag]   = bit_v;
    exp_val[tag]  = br ? '0 : word_t'(bit_v);
    exp_npc[tag]  = bit_v ? pc + imm : pc + 32'd4;
    lat_chk[tag]  = chk_lat;
    pend[tag]     = 1'b1;
endtask

// random pc and offset, j may wait on qj
task automatic issue_op(input cmp_op_t op, input word_t a, input word_t b,
                        input rob_tag_t qj, input logic chk_lat, output logic acked);
    rob_tag_t tag;
    word_t    pc;
    word_t    imm;
    word_t    r;
    tag = alloc_tag();
    pc  = rand_bits(30) << 2;
    r   = rand_bits(12);
    imm = {{19{r[11]}}, r[11:0], 1'b0};
    expect_result(tag, op, a, b, pc, imm, chk_lat);
    // stale j value, so a missed capture shows up
    put_issue(op, (qj != '0) ? ~a : a, qj, b, pc, imm, tag);
    inflight.push_back(tag);
    wait_ack(20, acked);
endtask

task automatic issue_checked(input cmp_op_t op, input word_t a, input word_t b,
                             input rob_tag_t qj, input logic chk_lat);
    logic acked;
    issue_op(op, a, b, qj, chk_lat, acked);
    assert (acked) else begin
        $display("issue at %0t was not acked within 20 cycles", $time);
        err_cnt++;
    end
endtask

// one-cycle cdb broadcast
task automatic broadcast(input rob_tag_t tag, input word_t value);
    cdb_valid_i = 1'b1;
    cdb_tag_i   = tag;
    cdb_value_i = value;
    step(1);
    cdb_valid_i = 1'b0;
endtask

// wait until every in-flight tag has retired
task automatic drain(input int max_cyc);
    rob_tag_t tag;
    int       n;
    while (inflight.size() > 0) begin
        tag = inflight.pop_front();
        n   = 0;
        while (pend[tag] && n < max_cyc) begin
            step(1);
            n++;
        end
        if (pend[tag]) begin
            $display("timeout: no result for tag %0d within %0d cycles", tag, max_cyc);
            err_cnt++;
        end
    end
endtask

// no cdb write and no redirect for n cycles
task automatic quiet_window(input int n_cyc);
    for (int i = 0; i < n_cyc; i++) begin
        step(1);
        assert (!cdb_out_valid_o && !redirect_valid_o) else begin
            $display("result output at %0t where none should appear", $time);
            err_cnt++;
        end
    end
endtask

`endif

// File: tb_cmp_unit.sv
`timescale 1ns/10ps
`include "cmp_consts.svh"

module tb_cmp_unit
    import cmp_pkg::*;
();

    localparam int NTAG = 1 << `CMP_TAG_W;

    logic     clk;
    logic     reset_i;
    logic     flush_i;
    logic     wb_cyc_i;
    logic     wb_stb_i;
    logic     wb_we_i;
    logic     wb_ack_o;
    cmp_op_t  iss_op_i;
    logic     iss_is_br_i;
    word_t    iss_vj_i;
    rob_tag_t iss_qj_i;
    word_t    iss_vk_i;
    rob_tag_t iss_qk_i;
    word_t    iss_pc_i;
    word_t    iss_imm_i;
    rob_tag_t iss_tag_i;
    logic     cdb_valid_i;
    rob_tag_t cdb_tag_i;
    word_t    cdb_value_i;
    logic     cdb_out_valid_o;
    rob_tag_t cdb_out_tag_o;
    word_t    cdb_out_value_o;
    logic     redirect_valid_o;
    logic     taken_o;
    word_t    next_pc_o;

    // scoreboard, indexed by destination tag
    logic     pend     [NTAG];
    logic     exp_br   [NTAG];
    logic     exp_tk   [NTAG];
    logic     lat_chk  [NTAG];
    word_t    exp_val  [NTAG];
    word_t    exp_npc  [NTAG];
    int       ack_cyc  [NTAG];
    rob_tag_t inflight [$];

    logic [15:0] lfsr;
    rob_tag_t    next_tag;
    int          cyc_cnt;
    int          err_cnt;
    int          err_mark;
    int          tests_run;
    int          tests_bad;

    always #2 clk = ~clk;

    cmp_unit_top cmp_unit_top_inst (.*);

    // cycle count for latency and retire of scoreboard results
    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (!reset_i && cdb_out_valid_o && pend[cdb_out_tag_o]) begin
            pend[cdb_out_tag_o] <= 1'b0;
        end
    end

    // galois lfsr, one step per bit taken
    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return r;
    endfunction

    // compare rule per funct3
    function automatic logic rule_bit(input cmp_op_t op, input word_t a, input word_t b);
        logic lt_u;
        logic lt_s;
        lt_u = (a < b);
        // with differing signs the negative operand is smaller
        lt_s = (a[31] != b[31]) ? a[31] : lt_u;
        case (op)
            F3_BEQ:           return a == b;
            F3_BNE:           return a != b;
            F3_BLT, F3_SLT:   return lt_s;
            F3_BGE:           return !lt_s;
            F3_BLTU, F3_SLTU: return lt_u;
            default:          return !lt_u;
        endcase
    endfunction

    // tags run 1..15 since zero marks a ready operand
    function automatic rob_tag_t alloc_tag();
        next_tag = (next_tag == rob_tag_t'(NTAG - 1)) ? rob_tag_t'(1) : next_tag + 1'b1;
        return next_tag;
    endfunction

    task automatic report_mismatch(input string name, input word_t exp, input word_t act);
        $display("** Error at %0t: %s expected %h got %h", $time, name, exp, act);
        err_cnt++;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_cnt != err_mark) begin
            tests_bad++;
        end
        $display("test %0d %s: %s, errors %0d", tests_run, name,
                 (err_cnt == err_mark) ? "ok" : "failed", err_cnt - err_mark);
        err_mark = err_cnt;
    endtask

    `include "cmp_tb_tasks.svh"

    // every result must belong to a pending tag
    a_known: assert property (@(posedge clk) disable iff (reset_i)
        cdb_out_valid_o |-> pend[cdb_out_tag_o])
        else begin
            $display("result for tag %0d at %0t was not expected", $sampled(cdb_out_tag_o), $time);
            err_cnt++;
        end

    a_value: assert property (@(posedge clk) disable iff (reset_i)
        cdb_out_valid_o |-> cdb_out_value_o == exp_val[cdb_out_tag_o])
        else report_mismatch("cdb_out_value_o", exp_val[$sampled(cdb_out_tag_o)],
                             $sampled(cdb_out_value_o));

    // redirect only for branches
    a_redirect: assert property (@(posedge clk) disable iff (reset_i)
        cdb_out_valid_o |-> redirect_valid_o == exp_br[cdb_out_tag_o])
        else report_mismatch("redirect_valid_o", exp_br[$sampled(cdb_out_tag_o)],
                             $sampled(redirect_valid_o));

    a_taken: assert property (@(posedge clk) disable iff (reset_i)
        redirect_valid_o |-> taken_o == exp_tk[cdb_out_tag_o])
        else report_mismatch("taken_o", exp_tk[$sampled(cdb_out_tag_o)], $sampled(taken_o));

    a_next_pc: assert property (@(posedge clk) disable iff (reset_i)
        redirect_valid_o |-> next_pc_o == exp_npc[cdb_out_tag_o])
        else report_mismatch("next_pc_o", exp_npc[$sampled(cdb_out_tag_o)],
                             $sampled(next_pc_o));

    // ready operands give the output 4 cycles after the ack cycle
    a_latency: assert property (@(posedge clk) disable iff (reset_i)
        (cdb_out_valid_o && lat_chk[cdb_out_tag_o])
        |-> (cyc_cnt - ack_cyc[cdb_out_tag_o]) == 4)
        else report_mismatch("cdb_out_valid_o latency", 4,
                             $sampled(cyc_cnt) - ack_cyc[$sampled(cdb_out_tag_o)]);

    initial begin
        cmp_op_t br_ops [6];
        word_t   a;
        word_t   b;
        logic    acked;
        br_ops      = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        clk         = 1'b0;
        reset_i     = 1'b1;
        flush_i     = 1'b0;
        wb_cyc_i    = 1'b0;
        wb_stb_i    = 1'b0;
        wb_we_i     = 1'b0;
        iss_op_i    = '0;
        iss_is_br_i = 1'b0;
        iss_vj_i    = '0;
        iss_qj_i    = '0;
        iss_vk_i    = '0;
        iss_qk_i    = '0;
        iss_pc_i    = '0;
        iss_imm_i   = '0;
        iss_tag_i   = '0;
        cdb_valid_i = 1'b0;
        cdb_tag_i   = '0;
        cdb_value_i = '0;
        lfsr        = 16'd10598;
        next_tag    = '0;
        cyc_cnt     = 0;
        err_cnt     = 0;
        err_mark    = 0;
        tests_run   = 0;
        tests_bad   = 0;
        for (int i = 0; i < NTAG; i++) begin
            pend[i]    = 1'b0;
            lat_chk[i] = 1'b0;
            ack_cyc[i] = 0;
        end
        step(3);
        reset_i = 1'b0;

        assert (!wb_ack_o) else report_mismatch("wb_ack_o", 0, wb_ack_o);
        assert (!cdb_out_valid_o) else report_mismatch("cdb_out_valid_o", 0, cdb_out_valid_o);
        assert (!redirect_valid_o) else report_mismatch("redirect_valid_o", 0, redirect_valid_o);
        end_test("reset");

        for (int i = 0; i < 6; i++) begin
            a = rand_bits(32);
            b = rand_bits(32);
            issue_checked(i[0] ? F3_SLTU : F3_SLT, a, b, '0, 1'b1);
        end
        drain(40);
        end_test("slt/sltu");

        // each branch once with random and once with equal operands
        for (int i = 0; i < 6; i++) begin
            a = rand_bits(32);
            b = rand_bits(32);
            issue_checked(br_ops[i], a, b, '0, 1'b1);
            issue_checked(br_ops[i], a, a, '0, 1'b1);
        end
        drain(40);
        end_test("branches");

        // beq on equal values only holds with the broadcast operand
        a = rand_bits(32);
        issue_checked(F3_BEQ, a, a, 4'd13, 1'b0);
        quiet_window(10);
        broadcast(4'd13, a);
        drain(40);
        end_test("cdb wait");

        // fill all four slots, all waiting on tag 9
        a = rand_bits(32);
        for (int i = 0; i < 4; i++) begin
            b = rand_bits(32);
            issue_checked(br_ops[i], a, b, 4'd9, 1'b0);
        end
        b = rand_bits(32);
        issue_op(F3_SLTU, b, a, '0, 1'b0, acked);
        assert (!acked) else begin
            $display("fifth issue was acked while the station was full");
            err_cnt++;
        end
        broadcast(4'd9, a);
        wait_ack(20, acked);
        assert (acked) else begin
            $display("fifth issue was not acked after a slot was freed");
            err_cnt++;
        end
        drain(60);
        end_test("back-pressure");

        a = rand_bits(32);
        b = rand_bits(32);
        issue_checked(F3_BNE, a, b, 4'd11, 1'b0);
        issue_checked(F3_SLT, a, b, 4'd11, 1'b0);
        flush_i = 1'b1;
        step(1);
        flush_i = 1'b0;
        // flushed entries never complete
        for (int i = 0; i < NTAG; i++) begin
            pend[i] = 1'b0;
        end
        inflight.delete();
        broadcast(4'd11, a);
        quiet_window(20);
        end_test("flush");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_bad, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule : tb_cmp_unit

// File: cmp_unit_top.sv
`timescale 1ns/10ps
`include "cmp_consts.svh"

module cmp_unit_top
    import cmp_pkg::*;
(
    input  logic     clk,
    input  logic     reset_i,
    input  logic     flush_i,
    // wishbone classic issue port
    input  logic     wb_cyc_i,
    input  logic     wb_stb_i,
    input  logic     wb_we_i,
    output logic     wb_ack_o,
    input  cmp_op_t  iss_op_i,
    input  logic     iss_is_br_i,
    input  word_t    iss_vj_i,
    input  rob_tag_t iss_qj_i,
    input  word_t    iss_vk_i,
    input  rob_tag_t iss_qk_i,
    input  word_t    iss_pc_i,
    input  word_t    iss_imm_i,
    input  rob_tag_t iss_tag_i,
    // cdb in
    input  logic     cdb_valid_i,
    input  rob_tag_t cdb_tag_i,
    input  word_t    cdb_value_i,
    // cdb out, rebroadcast outside
    output logic     cdb_out_valid_o,
    output rob_tag_t cdb_out_tag_o,
    output word_t    cdb_out_value_o,
    // redirect
    output logic     redirect_valid_o,
    output logic     taken_o,
    output word_t    next_pc_o
);

    // comparator result
    logic     ev_valid;
    logic     ev_is_br;
    logic     ev_bit;
    rob_tag_t ev_tag;

    // target result
    logic     bt_valid;
    word_t    bt_taken_pc;
    word_t    bt_fall_pc;

    cmp_dispatch_if u_disp ();

    cmp_rs u_rs (.*, .disp(u_disp.src));

    cmp_eval u_eval (
        .clk, .reset_i, .flush_i, .disp(u_disp.sink),
        .ev_valid_o(ev_valid), .ev_is_br_o(ev_is_br), .ev_bit_o(ev_bit), .ev_tag_o(ev_tag)
    );

    br_target u_target (
        .clk, .reset_i, .flush_i, .disp(u_disp.sink),
        .bt_valid_o(bt_valid), .bt_taken_pc_o(bt_taken_pc), .bt_fall_pc_o(bt_fall_pc)
    );

    br_resolve u_resolve (
        .clk, .reset_i, .flush_i,
        .ev_valid_i(ev_valid), .ev_is_br_i(ev_is_br), .ev_bit_i(ev_bit), .ev_tag_i(ev_tag),
        .bt_valid_i(bt_valid), .bt_taken_pc_i(bt_taken_pc), .bt_fall_pc_i(bt_fall_pc),
        .cdb_out_valid_o, .cdb_out_tag_o, .cdb_out_value_o,
        .redirect_valid_o, .taken_o, .next_pc_o
    );

endmodule : cmp_unit_top

// File: br_resolve.sv
`timescale 1ns/10ps
`include "cmp_consts.svh"

module br_resolve
    import cmp_pkg::*;
(
    input  logic     clk,
    input  logic     reset_i,
    input  logic     flush_i,
    // from comparator
    input  logic     ev_valid_i,
    input  logic     ev_is_br_i,
    input  logic     ev_bit_i,
    input  rob_tag_t ev_tag_i,
    // from target calculator
    input  logic     bt_valid_i,
    input  word_t    bt_taken_pc_i,
    input  word_t    bt_fall_pc_i,
    // cdb write
    output logic     cdb_out_valid_o,
    output rob_tag_t cdb_out_tag_o,
    output word_t    cdb_out_value_o,
    // fetch redirect
    output logic     redirect_valid_o,
    output logic     taken_o,
    output word_t    next_pc_o
);

    word_t res_value;

    // slt/sltu write the bit, branches write zero as a completion mark
    assign res_value = ev_is_br_i ? '0 : word_t'(ev_bit_i);

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            cdb_out_valid_o  <= 1'b0;
            redirect_valid_o <= 1'b0;
        end else begin
            cdb_out_valid_o  <= ev_valid_i;
            redirect_valid_o <= ev_valid_i && ev_is_br_i;
        end
    end

    // payload only, qualified by the valids above
    always_ff @(posedge clk) begin
        cdb_out_tag_o   <= ev_tag_i;
        cdb_out_value_o <= res_value;
        taken_o         <= ev_bit_i;
        // compare bit picks the target
        next_pc_o       <= ev_bit_i ? bt_taken_pc_i : bt_fall_pc_i;
    end

    // both units see the same dispatch, so their stages must stay aligned
    a_units_aligned: assert property (@(posedge clk) disable iff (reset_i)
        ev_valid_i == bt_valid_i);

endmodule : br_resolve

// File: br_target.sv
`timescale 1ns/10ps
`include "cmp_consts.svh"

module br_target
    import cmp_pkg::*;
(
    input  logic  clk,
    input  logic  reset_i,
    input  logic  flush_i,
    cmp_dispatch_if.sink disp,
    output logic  bt_valid_o,
    output word_t bt_taken_pc_o,
    output word_t bt_fall_pc_o
);

    // rv32i instruction size, no compressed
    localparam word_t INSN_BYTES = word_t'(4);

    word_t taken_pc;
    word_t fall_pc;

    // both targets every dispatch, resolve picks one later
    assign taken_pc = disp.pc + disp.imm;
    assign fall_pc  = disp.pc + INSN_BYTES;

    // valid tracks cmp_eval stage for stage
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            bt_valid_o <= 1'b0;
        end else begin
            bt_valid_o <= disp.valid;
        end
    end

    // slt/sltu also compute targets, ignored downstream
    always_ff @(posedge clk) begin
        bt_taken_pc_o <= taken_pc;
        bt_fall_pc_o  <= fall_pc;
    end

endmodule : br_target

// File: cmp_eval.sv
`timescale 1ns/10ps
`include "cmp_consts.svh"

module cmp_eval
    import cmp_pkg::*;
(
    input  logic     clk,
    input  logic     reset_i,
    input  logic     flush_i,
    cmp_dispatch_if.sink disp,
    output logic     ev_valid_o,
    output logic     ev_is_br_o,
    output logic     ev_bit_o,
    output rob_tag_t ev_tag_o
);

    logic eq;
    logic lt_s;
    logic lt_u;
    logic cmp_bit;

    // one shared equality and two less-than compares
    always_comb begin
        eq   = (disp.a == disp.b);
        lt_s = ($signed(disp.a) < $signed(disp.b));
        lt_u = (disp.a < disp.b);
        // bne, bge, bgeu invert their base compare
        case (disp.op)
            F3_BEQ:         cmp_bit = eq;
            F3_BNE:         cmp_bit = !eq;
            F3_BLT, F3_SLT:   cmp_bit = lt_s;
            F3_BGE:         cmp_bit = !lt_s;
            F3_BLTU, F3_SLTU: cmp_bit = lt_u;
            F3_BGEU:        cmp_bit = !lt_u;
            default:        cmp_bit = eq;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            ev_valid_o <= 1'b0;
        end else begin
            ev_valid_o <= disp.valid;
        end
    end

    // result payload, qualified by ev_valid_o
    always_ff @(posedge clk) begin
        ev_bit_o   <= cmp_bit;
        ev_is_br_o <= disp.is_br;
        ev_tag_o   <= disp.tag;
    end

endmodule : cmp_eval

// File: cmp_rs.sv
`timescale 1ns/10ps
`include "cmp_consts.svh"

module cmp_rs
    import cmp_pkg::*;
(
    input  logic     clk,
    input  logic     reset_i,
    input  logic     flush_i,
    // wishbone classic issue slave
    input  logic     wb_cyc_i,
    input  logic     wb_stb_i,
    input  logic     wb_we_i,
    output logic     wb_ack_o,
    input  cmp_op_t  iss_op_i,
    input  logic     iss_is_br_i,
    input  word_t    iss_vj_i,
    input  word_t    iss_vk_i,
    input  word_t    iss_pc_i,
    input  word_t    iss_imm_i,
    input  rob_tag_t iss_qj_i,
    input  rob_tag_t iss_qk_i,
    input  rob_tag_t iss_tag_i,
    // cdb broadcast
    input  logic     cdb_valid_i,
    input  rob_tag_t cdb_tag_i,
    input  word_t    cdb_value_i,
    cmp_dispatch_if.src disp
);

    localparam int RS_SIZE = `CMP_RS_SIZE;
    localparam int SLOT_W  = `CMP_SLOT_W;

    // slot control
    slot_state_t state_q [RS_SIZE];

    // slot payload
    word_t    vj_q     [RS_SIZE];
    word_t    vk_q     [RS_SIZE];
    rob_tag_t qj_q     [RS_SIZE];
    rob_tag_t qk_q     [RS_SIZE];
    logic     vj_ok_q  [RS_SIZE];
    logic     vk_ok_q  [RS_SIZE];
    cmp_op_t  op_q     [RS_SIZE];
    logic     is_br_q  [RS_SIZE];
    word_t    pc_q     [RS_SIZE];
    word_t    imm_q    [RS_SIZE];
    rob_tag_t tag_q    [RS_SIZE];

    logic [RS_SIZE-1:0] free_vec;
    logic [RS_SIZE-1:0] ready_vec;
    logic [SLOT_W-1:0]  alloc_idx;
    logic [SLOT_W-1:0]  disp_idx;
    logic [SLOT_W-1:0]  disp_slot_q;
    logic               any_free;
    logic               any_ready;
    logic               issue_go;

    // issue operands, possibly bypassed from a same-cycle broadcast
    logic  j_from_cdb;
    logic  k_from_cdb;
    logic  iss_j_ok;
    logic  iss_k_ok;
    word_t iss_j_val;
    word_t iss_k_val;

    // lowest free slot for allocation, lowest ready slot for dispatch
    always_comb begin
        alloc_idx = '0;
        disp_idx  = '0;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            free_vec[i]  = (state_q[i] == FREE);
            ready_vec[i] = (state_q[i] == READY);
            if (free_vec[i]) begin
                alloc_idx = SLOT_W'(i);
            end
            if (ready_vec[i]) begin
                disp_idx = SLOT_W'(i);
            end
        end
        any_free  = |free_vec;
        any_ready = |ready_vec;
    end

    // ack guard keeps a held strobe from issuing twice
    assign issue_go = wb_cyc_i && wb_stb_i && wb_we_i && !wb_ack_o && any_free;

    assign j_from_cdb = cdb_valid_i && (cdb_tag_i == iss_qj_i);
    assign k_from_cdb = cdb_valid_i && (cdb_tag_i == iss_qk_i);
    assign iss_j_ok   = (iss_qj_i == '0) || j_from_cdb;
    assign iss_k_ok   = (iss_qk_i == '0) || k_from_cdb;
    assign iss_j_val  = (iss_qj_i == '0) ? iss_vj_i : cdb_value_i;
    assign iss_k_val  = (iss_qk_i == '0) ? iss_vk_i : cdb_value_i;

    // ack, slot states and dispatch valid
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            wb_ack_o   <= 1'b0;
            disp.valid <= 1'b0;
            for (int i = 0; i < RS_SIZE; i++) begin
                state_q[i] <= FREE;
            end
        end else begin
            wb_ack_o   <= issue_go;
            disp.valid <= any_ready;
            for (int i = 0; i < RS_SIZE; i++) begin
                case (state_q[i])
                    FREE: begin
                        if (issue_go && alloc_idx == SLOT_W'(i)) begin
                            state_q[i] <= ISSUED;
                        end
                    end
                    // promote once both operand flags are set
                    ISSUED, WAITING: begin
                        state_q[i] <= (vj_ok_q[i] && vk_ok_q[i]) ? READY : WAITING;
                    end
                    READY: begin
                        if (disp_idx == SLOT_W'(i)) begin
                            state_q[i] <= FREE;
                        end
                    end
                    default: state_q[i] <= FREE;
                endcase
            end
        end
    end

    // slot write on issue, cdb capture and dispatch bundle
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_SIZE; i++) begin
            if (issue_go && alloc_idx == SLOT_W'(i)) begin
                vj_q[i]    <= iss_j_val;
                vk_q[i]    <= iss_k_val;
                qj_q[i]    <= iss_qj_i;
                qk_q[i]    <= iss_qk_i;
                vj_ok_q[i] <= iss_j_ok;
                vk_ok_q[i] <= iss_k_ok;
                op_q[i]    <= iss_op_i;
                is_br_q[i] <= iss_is_br_i;
                pc_q[i]    <= iss_pc_i;
                imm_q[i]   <= iss_imm_i;
                tag_q[i]   <= iss_tag_i;
            end else if (state_q[i] != FREE) begin
                // snoop the broadcast for missing operands
                if (!vj_ok_q[i] && cdb_valid_i && cdb_tag_i == qj_q[i]) begin
                    vj_q[i]    <= cdb_value_i;
                    vj_ok_q[i] <= 1'b1;
                end
                if (!vk_ok_q[i] && cdb_valid_i && cdb_tag_i == qk_q[i]) begin
                    vk_q[i]    <= cdb_value_i;
                    vk_ok_q[i] <= 1'b1;
                end
            end
        end
        if (any_ready) begin
            disp.op     <= op_q[disp_idx];
            disp.is_br  <= is_br_q[disp_idx];
            disp.a      <= vj_q[disp_idx];
            disp.b      <= vk_q[disp_idx];
            disp.pc     <= pc_q[disp_idx];
            disp.imm    <= imm_q[disp_idx];
            disp.tag    <= tag_q[disp_idx];
            disp_slot_q <= disp_idx;
        end
    end

    // each ack matches a slot that was FREE and now holds the new entry
    a_no_ack_when_full: assert property (@(posedge clk) disable iff (reset_i)
        $rose(wb_ack_o) |-> $past(state_q[alloc_idx] == FREE)
                            && (state_q[$past(alloc_idx)] == ISSUED));

    // dispatched slot was ready one edge earlier and has been released
    a_disp_from_ready: assert property (@(posedge clk) disable iff (reset_i || flush_i)
        disp.valid |-> (($past(ready_vec) & (RS_SIZE'(1) << disp_slot_q)) != '0)
                       && (state_q[disp_slot_q] == FREE));

endmodule : cmp_rs

// File: cmp_dispatch_if.sv
`timescale 1ns/10ps

interface cmp_dispatch_if
    import cmp_pkg::*;
();

    // one dispatched entry, registered in the station
    logic     valid;
    cmp_op_t  op;
    logic     is_br;
    // operand values, j then k
    word_t    a;
    word_t    b;
    word_t    pc;
    word_t    imm;
    // destination rob tag
    rob_tag_t tag;

    // station side
    modport src (output valid, op, is_br, a, b, pc, imm, tag);

    // comparator and target units
    modport sink (input valid, op, is_br, a, b, pc, imm, tag);

endinterface : cmp_dispatch_if

// File: cmp_pkg.sv
`include "cmp_consts.svh"

package cmp_pkg;

    // data or pc word
    typedef logic [`CMP_XLEN-1:0] word_t;

    // rob tag
    typedef logic [`CMP_TAG_W-1:0] rob_tag_t;

    // funct3 of the compare
    typedef logic [`CMP_FUNCT3_W-1:0] cmp_op_t;

    // ISSUED is the first cycle after allocation
    typedef enum logic [1:0] {FREE, WAITING, READY, ISSUED} slot_state_t;

    // rv32i funct3 encodings, branch and slt/sltu share the field
    localparam cmp_op_t F3_BEQ  = 3'b000;
    localparam cmp_op_t F3_BNE  = 3'b001;
    localparam cmp_op_t F3_SLT  = 3'b010;
    localparam cmp_op_t F3_SLTU = 3'b011;
    localparam cmp_op_t F3_BLT  = 3'b100;
    localparam cmp_op_t F3_BGE  = 3'b101;
    localparam cmp_op_t F3_BLTU = 3'b110;
    localparam cmp_op_t F3_BGEU = 3'b111;

endpackage : cmp_pkg

// File: cmp_consts.svh
`ifndef CMP_CONSTS_SVH
`define CMP_CONSTS_SVH

// data and pc width
`define CMP_XLEN 32

// rob tag width, tag zero means operand already valid
`define CMP_TAG_W 4

// compare funct3 width
`define CMP_FUNCT3_W 3

// station depth and slot index width
`define CMP_RS_SIZE 4
`define CMP_SLOT_W 2

`endif
